//--- compile.f
verilog/mem_hier_pkg.sv
verilog/cache_array.sv
verilog/cache_controller.sv
verilog/unified_mem.sv
verilog/mem_hierarchy.sv
dv/tb_mem_hierarchy.sv

//--- dv/mem_hierarchy_tests.txt
# op addr wdata expect: F fetch, L load, S store (expect unused), P fetch sent with next line
# Values in hex, expect is the word at addr after earlier stores, reset contents addr ^ C3A5
F 0000 0000 C3A5
F 1234 0000 D191
F 1236 0000 D193
L 2040 0000 E3E5
L 2041 0000 E3E4
L 2042 0000 E3E7
L 2043 0000 E3E6
S 2041 BEEF 0000
L 2041 0000 BEEF
L 2042 0000 E3E7
L 3540 0000 F6E5
L 2041 0000 BEEF
L 2043 0000 E3E6
S 5A0C 1357 0000
L 5A0C 0000 1357
L 770D 0000 B4A8
L 5A0C 0000 1357
P 4C88 0000 8F2D
L 6E30 0000 AD95
F 4C8B 0000 8F2E
F 2041 0000 BEEF

//--- dv/tb_mem_hierarchy.sv
module tb_mem_hierarchy;
	import mem_hier_pkg::*;

	localparam int    TIMEOUT  = 200;
	localparam word_t RULE_XOR = 16'hC3A5;

	logic  clk;
	logic  i_rst_n;
	word_t i_i_addr;
	word_t i_d_addr;
	word_t i_d_wdata;
	logic  i_d_re;
	logic  i_d_we;
	word_t o_instr;
	logic  o_i_rdy;
	word_t o_d_rdata;
	logic  o_d_rdy;

	int n_pass;
	int n_fail;
	bit aborted;

	// Stored words override the reset rule
	word_t shadow [word_t];
	bit    stored_line [line_addr_t];

	// Expected tag state of both caches
	bit   ic_valid [NUM_LINES];
	tag_t ic_tag   [NUM_LINES];
	bit   dc_valid [NUM_LINES];
	tag_t dc_tag   [NUM_LINES];

	mem_hierarchy #(
		.MEM_LATENCY (3)
	) i_mem_hierarchy (
		.clk       (clk),
		.i_rst_n   (i_rst_n),
		.i_i_addr  (i_i_addr),
		.o_instr   (o_instr),
		.o_i_rdy   (o_i_rdy),
		.i_d_addr  (i_d_addr),
		.i_d_wdata (i_d_wdata),
		.i_d_re    (i_d_re),
		.i_d_we    (i_d_we),
		.o_d_rdata (o_d_rdata),
		.o_d_rdy   (o_d_rdy)
	);

	always #10 clk = ~clk;

	function automatic word_t model_word(input word_t a);
		if (shadow.exists(a)) begin
			return shadow[a];
		end
		return a ^ RULE_XOR;
	endfunction

	function automatic bit predict_hit(input bit icache, input word_t a);
		index_t idx;
		tag_t   tg;
		idx = a[OFFSET_W +: INDEX_W];
		tg  = a[WORD_W-1 -: TAG_W];
		if (icache) begin
			return ic_valid[idx] && (ic_tag[idx] == tg);
		end
		return dc_valid[idx] && (dc_tag[idx] == tg);
	endfunction

	task automatic note_line(input bit icache, input word_t a);
		index_t idx;
		idx = a[OFFSET_W +: INDEX_W];
		if (icache) begin
			ic_valid[idx] = 1'b1;
			ic_tag[idx]   = a[WORD_W-1 -: TAG_W];
		end else begin
			dc_valid[idx] = 1'b1;
			dc_tag[idx]   = a[WORD_W-1 -: TAG_W];
		end
	endtask

	task automatic log_result(input int num, input byte op, input word_t a, input bit bad);
		if (bad) begin
			n_fail++;
			$display("test %0d %c %h failed", num, op, a);
		end else begin
			n_pass++;
			$display("test %0d %c %h passed", num, op, a);
		end
	endtask

	// Fetch and data request may go out at the same edge
	task automatic issue(input int i_num, input bit do_i, input word_t ia, input word_t iexp,
			input int d_num, input bit do_d, input bit st, input word_t da,
			input word_t dw, input word_t dexp);
		bit i_done;
		bit d_done;
		bit i_bad;
		bit d_bad;
		bit i_hit;
		bit d_hit;
		int n;
		i_done = !do_i;
		d_done = !do_d;
		i_bad  = 1'b0;
		d_bad  = 1'b0;
		i_hit  = predict_hit(1'b1, ia);
		d_hit  = predict_hit(1'b0, da);
		// Lines hit by a store are stale in the instruction cache model
		if (do_i && !stored_line.exists(ia[WORD_W-1:OFFSET_W]) && model_word(ia) != iexp) begin
			$display("test %0d: file word %h at %h disagrees with the shadow model",
				i_num, iexp, ia);
			i_bad = 1'b1;
		end
		if (do_d && !st && model_word(da) != dexp) begin
			$display("test %0d: file word %h at %h disagrees with the shadow model",
				d_num, dexp, da);
			d_bad = 1'b1;
		end
		@(posedge clk);
		if (do_i) begin
			i_i_addr <= ia;
		end
		if (do_d) begin
			i_d_addr  <= da;
			i_d_wdata <= dw;
			i_d_re    <= !st;
			i_d_we    <= st;
		end
		for (n = 0; n < TIMEOUT && !(i_done && d_done); n++) begin
			@(negedge clk);
			if (do_i && n == 0 && o_i_rdy !== i_hit) begin
				$display("error: test %0d o_i_rdy in the request cycle expected %h got %h",
					i_num, i_hit, o_i_rdy);
				i_bad = 1'b1;
			end
			if (do_d && n == 0 && o_d_rdy !== d_hit) begin
				$display("error: test %0d o_d_rdy in the request cycle expected %h got %h",
					d_num, d_hit, o_d_rdy);
				d_bad = 1'b1;
			end
			if (!i_done && o_i_rdy) begin
				i_done = 1'b1;
				if (o_instr !== iexp) begin
					$display("error: test %0d o_instr expected %h got %h",
						i_num, iexp, o_instr);
					i_bad = 1'b1;
				end
			end
			if (!d_done && o_d_rdy) begin
				d_done = 1'b1;
				if (!st && o_d_rdata !== dexp) begin
					$display("error: test %0d o_d_rdata expected %h got %h",
						d_num, dexp, o_d_rdata);
					d_bad = 1'b1;
				end
			end
			@(posedge clk);
			// Store lands at this edge and the request drops after it
			if (do_d && d_done) begin
				i_d_re <= 1'b0;
				i_d_we <= 1'b0;
			end
		end
		if (!i_done) begin
			$display("test %0d: fetch of %h timed out, o_i_rdy never rose", i_num, ia);
			i_bad   = 1'b1;
			aborted = 1'b1;
		end
		if (!d_done) begin
			$display("test %0d: access to %h timed out, o_d_rdy never rose", d_num, da);
			d_bad   = 1'b1;
			aborted = 1'b1;
		end
		if (do_i) begin
			note_line(1'b1, ia);
			log_result(i_num, "F", ia, i_bad);
		end
		if (do_d) begin
			note_line(1'b0, da);
			if (st) begin
				shadow[da] = dw;
				stored_line[da[WORD_W-1:OFFSET_W]] = 1'b1;
			end
			log_result(d_num, st ? "S" : "L", da, d_bad);
		end
	endtask

	initial begin
		int    fd;
		int    num;
		int    cnt;
		byte   op;
		word_t addr;
		word_t wdata;
		word_t exp;
		bit    pend;
		int    pend_num;
		word_t pend_addr;
		word_t pend_exp;
		bit    reset_bad;
		string line;
		clk       = 1'b0;
		i_rst_n   = 1'b0;
		i_i_addr  = '0;
		i_d_addr  = '0;
		i_d_wdata = '0;
		i_d_re    = 1'b0;
		i_d_we    = 1'b0;
		n_pass    = 0;
		n_fail    = 0;
		aborted   = 1'b0;
		pend      = 1'b0;
		pend_num  = 0;
		pend_addr = '0;
		pend_exp  = '0;
		reset_bad = 1'b0;
		num       = 0;
		repeat (10) @(posedge clk);
		i_rst_n <= 1'b1;
		@(negedge clk);
		if (o_i_rdy !== 1'b0) begin
			$display("error: reset check o_i_rdy expected 0 got %h", o_i_rdy);
			reset_bad = 1'b1;
		end
		if (o_d_rdy !== 1'b0) begin
			$display("error: reset check o_d_rdy expected 0 got %h", o_d_rdy);
			reset_bad = 1'b1;
		end
		if (reset_bad) begin
			$display("reset check failed");
			n_fail++;
		end else begin
			$display("reset check passed");
			n_pass++;
		end
		fd = $fopen("dv/mem_hierarchy_tests.txt", "r");
		if (fd == 0) begin
			$display("cannot open dv/mem_hierarchy_tests.txt");
			aborted = 1'b1;
		end
		while (fd != 0 && !aborted && $fgets(line, fd) != 0) begin
			if (line.len() < 2 || line[0] == "#") begin
				continue;
			end
			num++;
			cnt = $sscanf(line, "%c %h %h %h", op, addr, wdata, exp);
			if (cnt != 4) begin
				$display("test %0d: malformed line in the test file", num);
				n_fail++;
			end else if (op == "P") begin
				pend      = 1'b1;
				pend_num  = num;
				pend_addr = addr;
				pend_exp  = exp;
			end else if (op == "L" || op == "S") begin
				issue(pend_num, pend, pend_addr, pend_exp,
					num, 1'b1, op == "S", addr, wdata, exp);
				pend = 1'b0;
			end else if (op == "F") begin
				if (pend) begin
					issue(pend_num, 1'b1, pend_addr, pend_exp, 0, 1'b0, 1'b0, '0, '0, '0);
					pend = 1'b0;
				end
				issue(num, 1'b1, addr, exp, 0, 1'b0, 1'b0, '0, '0, '0);
			end else begin
				$display("test %0d: unknown operation %c in the test file", num, op);
				n_fail++;
			end
		end
		if (pend && !aborted) begin
			issue(pend_num, 1'b1, pend_addr, pend_exp, 0, 1'b0, 1'b0, '0, '0, '0);
		end
		if (fd != 0) begin
			$fclose(fd);
		end
		$display("%0d tests: %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
		if (n_fail == 0 && !aborted) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the cache hierarchy testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_mem_hierarchy -f compile.f -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q '\*\*\* TEST FAILED \*\*\*' sim.log; then
	echo "simulation reported failure"
	exit 1
fi
exit 0

//--- verilog/cache_array.sv
module cache_array (
	input  logic                clk,
	input  logic                i_rst_n,
	input  mem_hier_pkg::word_t i_addr,
	input  logic                i_fill,
	input  mem_hier_pkg::line_t i_fill_line,
	input  logic                i_word_we,
	input  mem_hier_pkg::word_t i_wdata,
	output logic                o_hit,
	output mem_hier_pkg::word_t o_word,
	output mem_hier_pkg::line_t o_line,
	output mem_hier_pkg::tag_t  o_tag,
	output logic                o_dirty
);
	import mem_hier_pkg::*;

	tag_t    tag;
	index_t  index;
	offset_t offset;
	line_t   merged;

	logic [NUM_LINES-1:0] valid;
	logic [NUM_LINES-1:0] dirty;
	tag_t                 tag_mem  [NUM_LINES];
	line_t                data_mem [NUM_LINES];

	// Address split
	assign tag    = i_addr[WORD_W-1 -: TAG_W];
	assign index  = i_addr[OFFSET_W +: INDEX_W];
	assign offset = i_addr[OFFSET_W-1:0];

	// Combinational lookup of the indexed line
	assign o_line  = data_mem[index];
	assign o_tag   = tag_mem[index];
	assign o_dirty = valid[index] & dirty[index];
	assign o_hit   = valid[index] && (tag_mem[index] == tag);
	assign o_word  = o_line[offset*WORD_W +: WORD_W];

	// Store word dropped into the current line
	always_comb begin
		merged = o_line;
		merged[offset*WORD_W +: WORD_W] = i_wdata;
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			valid <= '0;
			dirty <= '0;
		end else if (i_fill) begin
			valid[index] <= 1'b1;
			dirty[index] <= 1'b0;
		end else if (i_word_we) begin
			dirty[index] <= 1'b1;
		end
	end

	// Tag and data store
	always_ff @(posedge clk) begin
		if (i_fill) begin
			tag_mem[index]  <= tag;
			data_mem[index] <= i_fill_line;
		end else if (i_word_we) begin
			data_mem[index] <= merged;
		end
	end

endmodule

//--- verilog/cache_controller.sv
module cache_controller (
	input  logic                   clk,
	input  logic                   i_rst_n,
	input  mem_hier_pkg::word_t    i_i_addr,
	input  logic                   i_i_hit,
	input  mem_hier_pkg::word_t    i_d_addr,
	input  logic                   i_d_re,
	input  logic                   i_d_we,
	input  logic                   i_d_hit,
	input  logic                   i_d_dirty,
	input  mem_hier_pkg::tag_t     i_d_tag,
	input  mem_hier_pkg::line_t    i_d_line,
	input  logic                   i_mem_ack,
	output logic                   o_i_fill,
	output logic                   o_d_fill,
	output logic                   o_d_word_we,
	output logic                   o_d_rdy,
	output logic                   o_mem_req,
	output mem_hier_pkg::mem_req_t o_mem_req_pkt
);
	import mem_hier_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_WB,
		S_FILL_D,
		S_FILL_I,
		S_WAIT_ACK_LOW
	} state_t;

	state_t state;
	state_t state_nxt;
	state_t ret_state;
	state_t ret_state_nxt;
	logic   d_strobe;
	logic   d_miss;
	logic   d_serve;
	index_t d_index;

	assign d_strobe = i_d_re | i_d_we;
	assign d_miss   = d_strobe & ~i_d_hit;
	assign d_index  = i_d_addr[OFFSET_W +: INDEX_W];

	// Hits are served whenever no transaction is driving the data cache
	assign d_serve = (state == S_IDLE) || (state == S_WAIT_ACK_LOW);

	assign o_d_rdy     = d_serve & d_strobe & i_d_hit;
	assign o_d_word_we = o_d_rdy & i_d_we;

	// Four-phase master holds req through the whole request state
	assign o_mem_req = (state == S_WB) || (state == S_FILL_D) || (state == S_FILL_I);

	// Line written at the ack edge
	assign o_d_fill = (state == S_FILL_D) & i_mem_ack;
	assign o_i_fill = (state == S_FILL_I) & i_mem_ack;

	always_comb begin
		o_mem_req_pkt.write = (state == S_WB);
		o_mem_req_pkt.wdata = i_d_line;
		case (state)
			// Victim lives at the request index under the stored tag
			S_WB:     o_mem_req_pkt.addr = {i_d_tag, d_index};
			S_FILL_I: o_mem_req_pkt.addr = i_i_addr[WORD_W-1:OFFSET_W];
			default:  o_mem_req_pkt.addr = i_d_addr[WORD_W-1:OFFSET_W];
		endcase
	end

	always_comb begin
		state_nxt     = state;
		ret_state_nxt = ret_state;
		case (state)
			S_IDLE: begin
				// Data side goes first
				if (d_miss) begin
					state_nxt = i_d_dirty ? S_WB : S_FILL_D;
				end else if (!i_i_hit) begin
					state_nxt = S_FILL_I;
				end
			end
			S_WB: begin
				if (i_mem_ack) begin
					state_nxt     = S_WAIT_ACK_LOW;
					ret_state_nxt = S_FILL_D;
				end
			end
			S_FILL_D, S_FILL_I: begin
				if (i_mem_ack) begin
					state_nxt     = S_WAIT_ACK_LOW;
					ret_state_nxt = S_IDLE;
				end
			end
			S_WAIT_ACK_LOW: begin
				// No new request until memory drops ack
				if (!i_mem_ack) begin
					state_nxt = ret_state;
				end
			end
			default: begin
				state_nxt = S_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state     <= S_IDLE;
			ret_state <= S_IDLE;
		end else begin
			state     <= state_nxt;
			ret_state <= ret_state_nxt;
		end
	end

endmodule

//--- verilog/mem_hier_pkg.sv
package mem_hier_pkg;

	// Word and line geometry
	localparam int WORD_W         = 16;
	localparam int WORDS_PER_LINE = 4;
	localparam int LINE_W         = WORD_W * WORDS_PER_LINE;
	localparam int OFFSET_W       = $clog2(WORDS_PER_LINE);
	localparam int LINE_ADDR_W    = WORD_W - OFFSET_W;

	// Direct-mapped split of the line address
	localparam int INDEX_W   = 6;
	localparam int TAG_W     = LINE_ADDR_W - INDEX_W;
	localparam int NUM_LINES = 2 ** INDEX_W;

	// Backing store covers the whole address space
	localparam int MEM_LINES = 2 ** LINE_ADDR_W;

	// Word at address w powers up as w ^ MEM_INIT_XOR
	localparam logic [WORD_W-1:0] MEM_INIT_XOR = 16'hC3A5;

	typedef logic [WORD_W-1:0]      word_t;
	typedef logic [LINE_W-1:0]      line_t;
	typedef logic [LINE_ADDR_W-1:0] line_addr_t;
	typedef logic [TAG_W-1:0]       tag_t;
	typedef logic [INDEX_W-1:0]     index_t;
	typedef logic [OFFSET_W-1:0]    offset_t;

	// Controller to memory
	typedef struct packed {
		logic       write;
		line_addr_t addr;
		line_t      wdata;
	} mem_req_t;

	// Memory to controller
	typedef struct packed {
		line_t rdata;
	} mem_rsp_t;

endpackage

//--- verilog/mem_hierarchy.sv
module mem_hierarchy #(
	parameter int MEM_LATENCY = 3
) (
	input  logic                clk,
	input  logic                i_rst_n,
	// Instruction side
	input  mem_hier_pkg::word_t i_i_addr,
	output mem_hier_pkg::word_t o_instr,
	output logic                o_i_rdy,
	// Data side
	input  mem_hier_pkg::word_t i_d_addr,
	input  mem_hier_pkg::word_t i_d_wdata,
	input  logic                i_d_re,
	input  logic                i_d_we,
	output mem_hier_pkg::word_t o_d_rdata,
	output logic                o_d_rdy
);
	import mem_hier_pkg::*;

	logic     ic_fill;
	logic     dc_fill;
	logic     dc_word_we;
	logic     dc_hit;
	logic     dc_dirty;
	tag_t     dc_tag;
	line_t    dc_line;
	logic     mem_req;
	logic     mem_ack;
	mem_req_t mem_req_pkt;
	mem_rsp_t mem_rsp;

	// Read only so the word write is tied off
	cache_array u_icache (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_addr      (i_i_addr),
		.i_fill      (ic_fill),
		.i_fill_line (mem_rsp.rdata),
		.i_word_we   (1'b0),
		.i_wdata     ('0),
		.o_hit       (o_i_rdy),
		.o_word      (o_instr),
		.o_line      (),
		.o_tag       (),
		.o_dirty     ()
	);

	cache_array u_dcache (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_addr      (i_d_addr),
		.i_fill      (dc_fill),
		.i_fill_line (mem_rsp.rdata),
		.i_word_we   (dc_word_we),
		.i_wdata     (i_d_wdata),
		.o_hit       (dc_hit),
		.o_word      (o_d_rdata),
		.o_line      (dc_line),
		.o_tag       (dc_tag),
		.o_dirty     (dc_dirty)
	);

	cache_controller u_ctrl (
		.clk           (clk),
		.i_rst_n       (i_rst_n),
		.i_i_addr      (i_i_addr),
		.i_i_hit       (o_i_rdy),
		.i_d_addr      (i_d_addr),
		.i_d_re        (i_d_re),
		.i_d_we        (i_d_we),
		.i_d_hit       (dc_hit),
		.i_d_dirty     (dc_dirty),
		.i_d_tag       (dc_tag),
		.i_d_line      (dc_line),
		.i_mem_ack     (mem_ack),
		.o_i_fill      (ic_fill),
		.o_d_fill      (dc_fill),
		.o_d_word_we   (dc_word_we),
		.o_d_rdy       (o_d_rdy),
		.o_mem_req     (mem_req),
		.o_mem_req_pkt (mem_req_pkt)
	);

	unified_mem #(
		.MEM_LATENCY (MEM_LATENCY)
	) u_mem (
		.clk       (clk),
		.i_rst_n   (i_rst_n),
		.i_req     (mem_req),
		.i_req_pkt (mem_req_pkt),
		.o_ack     (mem_ack),
		.o_rsp     (mem_rsp)
	);

endmodule

//--- verilog/unified_mem.sv
module unified_mem #(
	parameter int MEM_LATENCY = 3
) (
	input  logic                   clk,
	input  logic                   i_rst_n,
	input  logic                   i_req,
	input  mem_hier_pkg::mem_req_t i_req_pkt,
	output logic                   o_ack,
	output mem_hier_pkg::mem_rsp_t o_rsp
);
	import mem_hier_pkg::*;

	localparam int CNT_W = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;

	typedef enum logic [1:0] {
		S_IDLE,
		S_COUNT,
		S_ACK
	} state_t;

	state_t           state;
	logic [CNT_W-1:0] cnt;
	logic             access;
	line_t            mem [MEM_LINES];

	// Last latency cycle
	assign access = (state == S_COUNT) && (cnt == CNT_W'(MEM_LATENCY - 1));

	// Fixed power-up contents
	initial begin
		for (int l = 0; l < MEM_LINES; l++) begin
			for (int w = 0; w < WORDS_PER_LINE; w++) begin
				mem[l][w*WORD_W +: WORD_W] = WORD_W'((l * WORDS_PER_LINE) + w) ^ MEM_INIT_XOR;
			end
		end
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= S_IDLE;
			cnt   <= '0;
			o_ack <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (i_req) begin
						state <= S_COUNT;
						cnt   <= '0;
					end
				end
				S_COUNT: begin
					if (access) begin
						state <= S_ACK;
						o_ack <= 1'b1;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				S_ACK: begin
					// Hold ack until the master lets go
					if (!i_req) begin
						state <= S_IDLE;
						o_ack <= 1'b0;
					end
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	always @(posedge clk) begin
		if (access) begin
			if (i_req_pkt.write) begin
				mem[i_req_pkt.addr] <= i_req_pkt.wdata;
			end
			o_rsp.rdata <= mem[i_req_pkt.addr];
		end
	end

endmodule
